// File: all.f
+incdir+test
logic/trellis_pkg.sv
logic/traceback_ctrl.sv
logic/survivor_history.sv
logic/state_walker.sv
logic/traceback_top.sv
test/traceback_tb.sv

// File: logic/state_walker.sv
// trace-back walker
// follows predecessors through the history and holds the output decision
`timescale 1ns/1ps
`default_nettype none

module state_walker
   import trellis_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          load,
   input  wire logic          step,
   input  wire logic          commit,
   input  wire logic          sym_even,
   input  wire state_t        index,
   input  wire survivor_col_t sel,
   input  wire dec_t          hist_dec,
   output state_t             read_state,
   output dec_t               decision
);

   state_t             cur_state;
   dec_t               cur_dec;
   logic [phase_w-1:0] phase_step;
   logic [phase_w-1:0] phase_delta;
   logic [phase_w-1:0] pred_phase;

   // ------------------------------
   // predecessor
   // ------------------------------
   always_comb begin
      phase_step  = sym_even ? phase_w'(phase_step_even) : phase_w'(phase_step_odd);
      phase_delta = phase_step * phase_w'(cur_dec);   // wraps mod 16
      pred_phase  = cur_state[state_w-1:dec_w] - phase_delta;
   end

   // low bits keep the decision
   assign read_state = {pred_phase, cur_dec};

   // ------------------------------
   // walk registers
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         cur_state <= '0;
         cur_dec   <= '0;
      end else if (load) begin
         cur_state <= index;
         cur_dec   <= sel[index];
      end else if (step) begin
         cur_state <= read_state;
         cur_dec   <= hist_dec;
      end
   end

   // output decision, updated once per finished walk
   always_ff @(posedge clk) begin
      if (reset) begin
         decision <= '0;
      end else if (commit) begin
         decision <= cur_dec;
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   walk_hold_a: assert property (@(posedge clk) disable iff (reset)
      (!load && !step && !commit) |=> ($stable(cur_state) && $stable(cur_dec)));

endmodule

`default_nettype wire

// File: logic/survivor_history.sv
// survivor history of the last tb_depth columns
// shifts in the current column on commit, read by state and column
`timescale 1ns/1ps
`default_nettype none

module survivor_history
   import trellis_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          commit,
   input  wire survivor_col_t sel,
   input  wire col_sel_t      col_sel,
   input  wire state_t        read_state,
   output dec_t               hist_dec
);

   // column 0 is the newest
   survivor_col_t [tb_depth-1:0] hist;

   // ------------------------------
   // column shift register
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         hist <= '0;
      end else if (commit) begin
         for (int i = tb_depth - 1; i > 0; i--) begin
            hist[i] <= hist[i-1];
         end
         hist[0] <= sel;
      end
   end

   // ------------------------------
   // read port
   // ------------------------------
   assign hist_dec = hist[col_sel][read_state];   // decision taken into read_state

   // ------------------------------
   // checks
   // ------------------------------
   // history only moves on the commit edge
   hist_hold_a: assert property (@(posedge clk) disable iff (reset)
      !commit |=> $stable(hist));

endmodule

`default_nettype wire

// File: logic/traceback_ctrl.sv
// trace-back sequencer
// load, one step per history column, then commit
`timescale 1ns/1ps
`default_nettype none

module traceback_ctrl
   import trellis_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire logic     sym_en,
   output logic          load,
   output logic          step,
   output col_sel_t      col_sel,
   output logic          commit
);

   typedef enum logic [1:0] {
      st_idle,
      st_load,
      st_walk,
      st_commit
   } ctrl_state_t;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   logic [2:0]  step_cnt;
   logic        last_step;

   assign last_step = (step_cnt == 3'(tb_depth - 1));

   // ------------------------------
   // state machine
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:   state_nxt = st_idle;
         st_load:   state_nxt = st_walk;
         st_walk:   if (last_step) state_nxt = st_commit;
         st_commit: state_nxt = st_idle;
         default:   state_nxt = st_idle;
      endcase
      if (sym_en) begin
         state_nxt = st_load;   // restart, also aborts a running walk
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // column counter, only runs in walk
   always_ff @(posedge clk) begin
      if (reset) begin
         step_cnt <= '0;
      end else if (state == st_walk) begin
         step_cnt <= step_cnt + 3'd1;
      end else begin
         step_cnt <= '0;
      end
   end

   assign load    = (state == st_load);
   assign step    = (state == st_walk);
   assign commit  = (state == st_commit);
   assign col_sel = step_cnt[1:0];

   // ------------------------------
   // checks
   // ------------------------------
   strobe_excl_a: assert property (@(posedge clk) disable iff (reset)
      $onehot0({load, step, commit}));

   col_range_a: assert property (@(posedge clk) disable iff (reset)
      step |-> (col_sel < tb_depth));

   // no commit without the walk reaching the oldest column
   commit_after_walk_a: assert property (@(posedge clk) disable iff (reset)
      commit |-> $past(step && (col_sel == col_sel_t'(tb_depth - 1))));

endmodule

`default_nettype wire

// File: logic/traceback_top.sv
// multi-h Viterbi trace-back
// sequencer, survivor history and state walker
`timescale 1ns/1ps
`default_nettype none

module traceback_top
   import trellis_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          sym_en,
   input  wire logic          sym_even,
   input  wire survivor_col_t sel,
   input  wire state_t        index,
   output dec_t               decision
);

   logic     load;
   logic     step;
   logic     commit;
   col_sel_t col_sel;
   state_t   read_state;
   dec_t     hist_dec;

   traceback_ctrl i_traceback_ctrl (
      .clk     (clk),
      .reset   (reset),
      .sym_en  (sym_en),
      .load    (load),
      .step    (step),
      .col_sel (col_sel),
      .commit  (commit)
   );

   survivor_history i_survivor_history (
      .clk        (clk),
      .reset      (reset),
      .commit     (commit),
      .sel        (sel),
      .col_sel    (col_sel),
      .read_state (read_state),
      .hist_dec   (hist_dec)
   );

   state_walker i_state_walker (
      .clk        (clk),
      .reset      (reset),
      .load       (load),
      .step       (step),
      .commit     (commit),
      .sym_even   (sym_even),
      .index      (index),
      .sel        (sel),
      .hist_dec   (hist_dec),
      .read_state (read_state),
      .decision   (decision)
   );

endmodule

`default_nettype wire

// File: logic/trellis_pkg.sv
// trellis package for the multi-h trace-back
// sizes, decision and state types, survivor column layout
`default_nettype none

package trellis_pkg;

   // ------------------------------
   // trellis sizes
   // ------------------------------
   localparam int num_states = 64;
   localparam int state_w    = 6;
   localparam int dec_w      = 2;   // decision is the low part of a state
   localparam int phase_w    = 4;   // upper bits of a state
   localparam int tb_depth   = 3;   // history columns walked

   // phase step per decision
   localparam int phase_step_even = 5;
   localparam int phase_step_odd  = 4;

   // ------------------------------
   // types
   // ------------------------------
   typedef logic [dec_w-1:0]   dec_t;
   typedef logic [state_w-1:0] state_t;

   // one survivor decision per state, entry n belongs to state n
   typedef logic [num_states-1:0][dec_w-1:0] survivor_col_t;

   typedef logic [$clog2(tb_depth)-1:0] col_sel_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the trace-back testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=traceback_sim
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
   -f all.f \
   --top-module traceback_tb \
   -Mdir "$build_dir" \
   -o "$sim_bin"
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TESTS PASSED" "$log_file"; then
   echo "simulation run ok"
   exit 0
else
   echo "simulation run failed"
   exit 1
fi

// File: test/traceback_model.svh
// trace-back reference model
// LFSR source, predecessor rule and walk over a three-column model history
`ifndef TRACEBACK_MODEL_SVH
`define TRACEBACK_MODEL_SVH

// ------------------------------
// random source
// ------------------------------
// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// ------------------------------
// trellis rule
// ------------------------------
// predecessor keeps the decision as its low bits
function automatic state_t predecessor(input state_t s, input dec_t d, input logic even);
   logic [phase_w-1:0] phase;
   int                 step_size;
   step_size = even ? phase_step_even : phase_step_odd;
   phase     = s[state_w-1:dec_w];
   phase     = phase - phase_w'(step_size * int'(d));   // modulo 16
   return {phase, d};
endfunction

// expected symbol decision for one complete walk
// col0 is the newest stored column, col2 the oldest
function automatic dec_t ref_walk(
   input state_t        start,
   input survivor_col_t cur_col,
   input logic          even,
   input survivor_col_t col0,
   input survivor_col_t col1,
   input survivor_col_t col2
);
   survivor_col_t cols [tb_depth];
   state_t        s;
   dec_t          d;
   cols[0] = col0;
   cols[1] = col1;
   cols[2] = col2;
   s = start;
   d = cur_col[start];   // decision into the best state
   for (int c = 0; c < tb_depth; c++) begin
      s = predecessor(s, d, even);
      d = cols[c][s];
   end
   return d;
endfunction

`endif

// File: test/traceback_tb.sv
// testbench for the multi-h trace-back
// random symbols against a reference walk, plus restart and hold checks
`timescale 1ns/1ps
`default_nettype none

module traceback_tb
   import trellis_pkg::*;
();

   `include "traceback_model.svh"

   localparam logic [31:0] lfsr_seed      = 32'h6c2e_ff8a;
   localparam int          commit_timeout = 20;
   localparam int          commit_delay   = 5;   // edges from strobe to output

   logic          clk;
   logic          reset;
   logic          sym_en;
   logic          sym_even;
   survivor_col_t sel;
   state_t        index;
   dec_t          decision;

   logic [31:0]   lfsr_state;
   survivor_col_t model_hist [tb_depth];
   dec_t          last_dec;   // model output once the pending walk commits
   int            even_cnt = 0;
   int            odd_cnt  = 0;

   // expected commit edge tracking
   int            commit_cnt  = 0;
   logic          commit_edge = 1'b0;
   logic          in_reset    = 1'b1;
   dec_t          held_dec    = '0;

   traceback_top i_traceback_top (
      .clk      (clk),
      .reset    (reset),
      .sym_en   (sym_en),
      .sym_even (sym_even),
      .sel      (sel),
      .index    (index),
      .decision (decision)
   );

   always #20 clk = ~clk;

   // ------------------------------
   // failure reporting
   // ------------------------------
   task automatic value_fail(input string name, input dec_t expected, input dec_t actual);
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "decision check failed");
   endtask

   task automatic abort_run(input string why);
      $display("error: %s", why);
      $display("TESTS FAILED");
      $fatal(1, "run aborted");
   endtask

   // ------------------------------
   // monitors
   // ------------------------------
   always @(posedge clk) begin
      in_reset <= reset;
      if (reset) begin
         commit_cnt  <= 0;
         commit_edge <= 1'b0;
      end else begin
         commit_edge <= (commit_cnt == 1);   // last edge of an unbroken walk
         if (sym_en) begin
            commit_cnt <= commit_delay;
         end else if (commit_cnt != 0) begin
            commit_cnt <= commit_cnt - 1;
         end
      end
   end

   // output may only move on the expected commit edge
   always @(negedge clk) begin
      if (commit_edge) begin
         held_dec = last_dec;
      end else begin
         assert (decision === held_dec)
            else value_fail(in_reset ? "reset" : "hold", held_dec, decision);
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic draw_bits(input int n, output logic [127:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         bits       = {bits[126:0], lfsr_state[0]};
      end
   endtask

   task automatic load_inputs();
      logic [127:0] bits;
      draw_bits(num_states * dec_w, bits);
      sel = bits;
      draw_bits(state_w, bits);
      index = bits[state_w-1:0];
      draw_bits(1, bits);
      sym_even = bits[0];
      if (sym_even) even_cnt++;
      else odd_cnt++;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic pulse_sym_en();
      sym_en = 1'b1;
      @(negedge clk);
      sym_en = 1'b0;
   endtask

   task automatic shift_model(input survivor_col_t col);
      for (int c = tb_depth - 1; c > 0; c--) begin
         model_hist[c] = model_hist[c-1];
      end
      model_hist[0] = col;
   endtask

   task automatic wait_commit(input string name);
      int waited;
      waited = 0;
      while (!commit_edge && waited < commit_timeout) begin
         @(negedge clk);
         waited++;
      end
      if (!commit_edge) abort_run({"no commit edge seen in ", name});
   endtask

   // ------------------------------
   // symbol sequences
   // ------------------------------
   task automatic run_symbol(input string name);
      dec_t exp_dec;
      load_inputs();
      exp_dec = ref_walk(index, sel, sym_even, model_hist[0], model_hist[1], model_hist[2]);
      last_dec = exp_dec;
      pulse_sym_en();
      wait_commit(name);
      assert (decision === exp_dec) else value_fail(name, exp_dec, decision);
      shift_model(sel);
      idle(8);
   endtask

   // second strobe two cycles in aborts the first walk
   task automatic run_restart();
      dec_t exp_dec;
      load_inputs();
      pulse_sym_en();
      idle(1);
      load_inputs();
      exp_dec = ref_walk(index, sel, sym_even, model_hist[0], model_hist[1], model_hist[2]);
      pulse_sym_en();
      idle(2);   // where the aborted walk would have committed
      assert (decision === last_dec) else value_fail("restart_abort", last_dec, decision);
      last_dec = exp_dec;
      wait_commit("restart");
      assert (decision === exp_dec) else value_fail("restart", exp_dec, decision);
      shift_model(sel);
      idle(8);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      sym_en     = 1'b0;
      sym_even   = 1'b0;
      sel        = '0;
      index      = '0;
      lfsr_state = lfsr_seed;
      last_dec   = '0;
      for (int c = 0; c < tb_depth; c++) begin
         model_hist[c] = '0;
      end

      repeat (16) @(negedge clk);
      reset = 1'b0;
      idle(2);

      for (int i = 0; i < tb_depth; i++) run_symbol("empty_hist");
      for (int i = 0; i < 200; i++) run_symbol("random_walk");
      if (even_cnt == 0 || odd_cnt == 0) abort_run("random symbols missed one parity");

      for (int i = 0; i < 4; i++) run_restart();
      for (int i = 0; i < 20; i++) run_symbol("after_restart");

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
